// File: build.f
+incdir+hw
hw/bp_pkg.sv
hw/bp_btb.sv
hw/bp_gshare_bht.sv
hw/branch_predictor.sv
dv/tb_clk_gen.sv
dv/tb_branch_predictor.sv

// File: dv/tb_branch_predictor.sv
// Branch predictor testbench

`timescale 1ns/1ps

`include "bp_defines.svh"

module tb_branch_predictor;

    localparam int BTB_N = `BP_BTB_ENTRIES;
    localparam int BTB_W = $clog2(BTB_N);
    localparam int BHT_N = `BP_BHT_ENTRIES;
    localparam int RESET_TIMEOUT = 20;

    logic          clk;
    logic          rst_ni;
    bp_pkg::addr_t pc_i;
    logic          predict_taken_o;
    bp_pkg::addr_t predict_target_o;
    logic          btb_hit_o;
    logic          update_i;
    logic          is_branch_i;
    bp_pkg::addr_t update_pc_i;
    logic          actual_taken_i;
    bp_pkg::addr_t actual_target_i;

    int err_cnt;
    int chk_cnt;
    int seed;

    // Reference tables
    logic          mdl_valid [BTB_N];
    bp_pkg::addr_t mdl_tag   [BTB_N];
    bp_pkg::addr_t mdl_tgt   [BTB_N];
    bp_pkg::ctr_t  mdl_ctr   [BHT_N];
    bp_pkg::ghr_t  mdl_ghr;

    tb_clk_gen #(.PERIOD_NS(20)) clk_gen_i (.clk_o(clk));

    branch_predictor branch_predictor_i (
        .clk_i            (clk),
        .rst_ni           (rst_ni),
        .pc_i             (pc_i),
        .predict_taken_o  (predict_taken_o),
        .predict_target_o (predict_target_o),
        .btb_hit_o        (btb_hit_o),
        .update_i         (update_i),
        .is_branch_i      (is_branch_i),
        .update_pc_i      (update_pc_i),
        .actual_taken_i   (actual_taken_i),
        .actual_target_i  (actual_target_i)
    );

    // ========================================================================
    // Reference model
    // ========================================================================

    function automatic int btb_slot(bp_pkg::addr_t pc);
        return int'((pc >> 2) & (BTB_N - 1));
    endfunction

    // Gshare hash with the current history
    function automatic int bht_slot(bp_pkg::addr_t pc);
        return int'(((pc >> 2) ^ mdl_ghr) & (BHT_N - 1));
    endfunction

    task automatic model_reset();
        for (int i = 0; i < BTB_N; i++) begin
            mdl_valid[i] = 1'b0;
        end
        // Weakly not-taken
        for (int i = 0; i < BHT_N; i++) begin
            mdl_ctr[i] = 2'b01;
        end
        mdl_ghr = '0;
    endtask

    task automatic model_update(bp_pkg::addr_t pc, logic taken, bp_pkg::addr_t tgt);
        int b;
        int h;
        b = btb_slot(pc);
        h = bht_slot(pc);
        mdl_valid[b] = 1'b1;
        mdl_tag[b]   = pc >> (BTB_W + 2);
        mdl_tgt[b]   = tgt;
        if (taken && mdl_ctr[h] != 2'b11) begin
            mdl_ctr[h] = mdl_ctr[h] + 2'd1;
        end else if (!taken && mdl_ctr[h] != 2'b00) begin
            mdl_ctr[h] = mdl_ctr[h] - 2'd1;
        end
        mdl_ghr = {mdl_ghr[`BP_GHR_WIDTH-2:0], taken};
    endtask

    // ========================================================================
    // Compare tasks
    // ========================================================================

    task automatic check_addr(string what, bp_pkg::addr_t got, bp_pkg::addr_t exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("[ERROR] %0t ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(string what, logic got, logic exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("[ERROR] %0t ns: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    // Drive a lookup and an optional update for one cycle
    // The lookup is checked against the model state before that update lands
    task automatic drive_cycle(logic upd, logic br, bp_pkg::addr_t upc, logic taken,
                               bp_pkg::addr_t tgt, bp_pkg::addr_t lpc);
        int            b;
        logic          exp_hit;
        bp_pkg::addr_t exp_tgt;
        logic          exp_taken;
        @(posedge clk);
        update_i        <= upd;
        is_branch_i     <= br;
        update_pc_i     <= upc;
        actual_taken_i  <= taken;
        actual_target_i <= tgt;
        pc_i            <= lpc;
        @(negedge clk);
        b         = btb_slot(lpc);
        exp_hit   = mdl_valid[b] && (mdl_tag[b] == (lpc >> (BTB_W + 2)));
        exp_tgt   = exp_hit ? mdl_tgt[b] : lpc + 32'd4;
        exp_taken = exp_hit && mdl_ctr[bht_slot(lpc)][1];
        check_bit("btb_hit_o", btb_hit_o, exp_hit);
        check_bit("predict_taken_o", predict_taken_o, exp_taken);
        check_addr("predict_target_o", predict_target_o, exp_tgt);
        // DUT applies the strobe at the next rising edge
        if (upd && br) begin
            model_update(upc, taken, tgt);
        end
    endtask

    task automatic report_test(string name, int errs_before);
        $display("Test %s done with %0d errors", name, err_cnt - errs_before);
    endtask

    // ========================================================================
    // Directed tests
    // ========================================================================

    task automatic reset_lookups();
        int e;
        e = err_cnt;
        drive_cycle(0, 0, '0, 0, '0, 32'h0000_0000);
        drive_cycle(0, 0, '0, 0, '0, 32'h0000_0100);
        drive_cycle(0, 0, '0, 0, '0, 32'h8000_0040);
        drive_cycle(0, 0, '0, 0, '0, 32'h1234_5678);
        report_test("reset_lookups", e);
    endtask

    task automatic install_and_hit();
        int e;
        e = err_cnt;
        drive_cycle(1, 1, 32'h0000_1040, 1, 32'h0000_2000, 32'h0000_1040);
        drive_cycle(0, 0, '0, 0, '0, 32'h0000_1040);
        report_test("install_and_hit", e);
    endtask

    // C differs from B in the lowest index bit, so after B saturates the
    // history at all ones a not-taken update lands on the lookup slot of C
    task automatic counter_hysteresis();
        int e;
        e = err_cnt;
        drive_cycle(1, 1, 32'h0000_3084, 1, 32'h0000_3200, 32'h0000_3084);
        for (int i = 0; i < 12; i++) begin
            drive_cycle(1, 1, 32'h0000_3080, 1, 32'h0000_3100, 32'h0000_3080);
        end
        drive_cycle(1, 1, 32'h0000_3080, 0, 32'h0000_3100, 32'h0000_3080);
        drive_cycle(0, 0, '0, 0, '0, 32'h0000_3084);
        if (mdl_ctr[bht_slot(32'h0000_3084)] == 2'b10) begin
            check_bit("taken with counter at 10", predict_taken_o, 1'b1);
        end else begin
            err_cnt++;
            $display("Hysteresis test did not bring the counter to weakly taken");
        end
        report_test("counter_hysteresis", e);
    endtask

    task automatic tag_replacement();
        int e;
        e = err_cnt;
        drive_cycle(1, 1, 32'h0000_4100, 1, 32'h0000_5000, 32'h0000_4100);
        drive_cycle(0, 0, '0, 0, '0, 32'h0000_4100);
        // Same BTB index with a different tag
        drive_cycle(1, 1, 32'h0000_4200, 1, 32'h0000_6000, 32'h0000_4200);
        drive_cycle(0, 0, '0, 0, '0, 32'h0000_4100);
        drive_cycle(0, 0, '0, 0, '0, 32'h0000_4200);
        report_test("tag_replacement", e);
    endtask

    // Follows counter_hysteresis, where C predicts taken only because its
    // counter sits at 10 under the current history
    task automatic non_branch_ignored();
        int e;
        e = err_cnt;
        drive_cycle(1, 0, 32'h7000_0000, 1, 32'h7000_1000, 32'h7000_0000);
        drive_cycle(0, 0, '0, 0, '0, 32'h7000_0000);
        // A history shift moves C onto an untouched counter
        drive_cycle(1, 0, 32'h0000_3084, 0, 32'h7000_2000, 32'h0000_3084);
        // A not-taken step on the counter of C would clear its taken bit
        drive_cycle(0, 0, '0, 0, '0, 32'h0000_3084);
        report_test("non_branch_ignored", e);
    endtask

    task automatic random_stream();
        bp_pkg::addr_t pcs [8];
        logic          upd;
        logic          br;
        logic          taken;
        bp_pkg::addr_t upc;
        bp_pkg::addr_t tgt;
        bp_pkg::addr_t lpc;
        int            e;
        e = err_cnt;
        pcs = '{32'h0000_1000, 32'h0000_1100, 32'h0000_1004, 32'h0000_2000,
                32'h0000_2400, 32'h0000_1008, 32'h0000_3080, 32'h0000_3084};
        for (int i = 0; i < 200; i++) begin
            upd   = ($random(seed) & 1) != 0;
            br    = ({$random(seed)} % 4) != 0;
            upc   = pcs[{$random(seed)} % 8];
            taken = ($random(seed) & 1) != 0;
            tgt   = $random(seed) & 32'hFFFF_FFFC;
            lpc   = pcs[{$random(seed)} % 8];
            drive_cycle(upd, br, upc, taken, tgt, lpc);
        end
        drive_cycle(0, 0, '0, 0, '0, pcs[0]);
        report_test("random_stream", e);
    endtask

    // ========================================================================
    // Main sequence
    // ========================================================================

    initial begin
        int waited;
        seed            = 56;
        err_cnt         = 0;
        chk_cnt         = 0;
        rst_ni          = 1'b0;
        pc_i            = '0;
        update_i        = 1'b0;
        is_branch_i     = 1'b0;
        update_pc_i     = '0;
        actual_taken_i  = 1'b0;
        actual_target_i = '0;
        model_reset();
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
        end
        rst_ni <= 1'b1;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while ((rst_ni !== 1'b1 || btb_hit_o !== 1'b0) && waited < RESET_TIMEOUT);
        if (waited >= RESET_TIMEOUT) begin
            $display("DUT did not come out of reset within %0d cycles", RESET_TIMEOUT);
            $display("Checks failed");
        end else begin
            reset_lookups();
            install_and_hit();
            counter_hysteresis();
            non_branch_ignored();
            tag_replacement();
            random_stream();
            $display("Checks run: %0d, errors: %0d", chk_cnt, err_cnt);
            if (err_cnt == 0) begin
                $display("All checks passed");
            end else begin
                $display("Checks failed");
            end
        end
        $finish;
    end

    // Watchdog for a stalled run
    initial begin
        #200us;
        $display("Simulation ran past its time limit");
        $display("Checks failed");
        $finish;
    end

endmodule

// File: dv/tb_clk_gen.sv
// Testbench clock source

`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int unsigned PERIOD_NS = 20
) (
    output logic clk_o
);

    // Free running, starts low
    initial begin
        clk_o = 1'b0;
    end

    always #(PERIOD_NS / 2) clk_o = ~clk_o;

endmodule

// File: hw/bp_btb.sv
// Branch target buffer
// Direct mapped with one tag and target per entry

`timescale 1ns/1ps

`include "bp_defines.svh"

module bp_btb #(
    parameter int unsigned BTB_ENTRIES = `BP_BTB_ENTRIES
) (
    input  logic          clk_i,
    input  logic          rst_ni,

    // Combinational lookup port
    input  bp_pkg::addr_t lookup_pc_i,
    output logic          hit_o,
    output bp_pkg::addr_t target_o,

    // Write port
    // Takes effect at the next rising edge
    input  logic          wr_en_i,
    input  bp_pkg::addr_t wr_pc_i,
    input  bp_pkg::addr_t wr_target_i
);

    // =======================================================================
    // Address split
    // =======================================================================

    // Instructions are word aligned so pc[1:0] is never stored
    localparam int unsigned IDX_W = $clog2(BTB_ENTRIES);
    localparam int unsigned TAG_W = `BP_ADDR_WIDTH - IDX_W - 2;

    typedef logic [IDX_W-1:0] idx_t;
    typedef logic [TAG_W-1:0] tag_t;

    // Entry storage
    logic [BTB_ENTRIES-1:0] valid_q;
    tag_t                   tag_q    [BTB_ENTRIES];
    bp_pkg::addr_t          target_q [BTB_ENTRIES];

    // Lookup side index and tag
    idx_t lookup_idx;
    tag_t lookup_tag;

    // Write side index and tag
    idx_t wr_idx;
    tag_t wr_tag;

    assign lookup_idx = lookup_pc_i[IDX_W+1:2];
    assign lookup_tag = lookup_pc_i[`BP_ADDR_WIDTH-1:IDX_W+2];

    assign wr_idx = wr_pc_i[IDX_W+1:2];
    assign wr_tag = wr_pc_i[`BP_ADDR_WIDTH-1:IDX_W+2];

    // =======================================================================
    // Lookup
    // =======================================================================

    // Hit needs a valid entry whose tag matches the upper PC bits
    assign hit_o = valid_q[lookup_idx] && (tag_q[lookup_idx] == lookup_tag);

    // Target is only meaningful together with hit_o
    assign target_o = target_q[lookup_idx];

    // =======================================================================
    // Write
    // =======================================================================

    // Valid bits are the only state cleared by reset
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
        end else if (wr_en_i) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    // Tag and target overwrite whatever the entry held
    always_ff @(posedge clk_i) begin
        if (wr_en_i) begin
            tag_q[wr_idx]    <= wr_tag;
            target_q[wr_idx] <= wr_target_i;
        end
    end

    // Write enable comes from the top level strobe gating
    // An unknown value here would corrupt a random entry
    a_wr_en_known: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        !$isunknown(wr_en_i)
    ) else $error("BTB write enable is unknown");

endmodule

// File: hw/bp_defines.svh
// Branch predictor sizing macros

`ifndef BP_DEFINES_SVH
`define BP_DEFINES_SVH

// ===========================================================================
// Address and table sizes
// ===========================================================================

// Width of a program counter or a branch target
`define BP_ADDR_WIDTH 32

// Default number of BTB entries
// Must be a power of two
`define BP_BTB_ENTRIES 64

// Default number of BHT counters
// Must be a power of two
`define BP_BHT_ENTRIES 256

// Global history length in outcomes
// Must cover the BHT index width
`define BP_GHR_WIDTH 8

`endif

// File: hw/bp_gshare_bht.sv
// Gshare branch history table

`timescale 1ns/1ps

`include "bp_defines.svh"

module bp_gshare_bht #(
    parameter int unsigned BHT_ENTRIES = `BP_BHT_ENTRIES
) (
    input  logic          clk_i,
    input  logic          rst_ni,

    // Combinational direction lookup
    input  bp_pkg::addr_t lookup_pc_i,
    output logic          taken_o,

    // Resolved branch outcome from execute
    input  logic          upd_en_i,
    input  bp_pkg::addr_t upd_pc_i,
    input  logic          upd_taken_i
);

    localparam int unsigned IDX_W = $clog2(BHT_ENTRIES);

    // Counter encodings
    localparam bp_pkg::ctr_t CTR_RESET = 2'b01;
    localparam bp_pkg::ctr_t CTR_MIN   = 2'b00;
    localparam bp_pkg::ctr_t CTR_MAX   = 2'b11;

    typedef logic [IDX_W-1:0] idx_t;

    bp_pkg::ctr_t ctr_q [BHT_ENTRIES];
    bp_pkg::ghr_t ghr_q;

    idx_t         lookup_idx;
    idx_t         upd_idx;
    bp_pkg::ctr_t upd_ctr;
    bp_pkg::ctr_t upd_ctr_next;

    // =======================================================================
    // Gshare indexing
    // =======================================================================

    // Both sides hash with the history as it stands before any shift
    assign lookup_idx = ghr_q[IDX_W-1:0] ^ lookup_pc_i[IDX_W+1:2];
    assign upd_idx    = ghr_q[IDX_W-1:0] ^ upd_pc_i[IDX_W+1:2];

    // Counter MSB gives the direction
    assign taken_o = ctr_q[lookup_idx][1];

    // Saturating step toward the actual outcome
    assign upd_ctr = ctr_q[upd_idx];

    always_comb begin
        upd_ctr_next = upd_ctr;
        if (upd_taken_i) begin
            if (upd_ctr != CTR_MAX) begin
                upd_ctr_next = upd_ctr + 2'd1;
            end
        end else if (upd_ctr != CTR_MIN) begin
            upd_ctr_next = upd_ctr - 2'd1;
        end
    end

    // =======================================================================
    // State update
    // =======================================================================

    // Counters start weakly not-taken and history starts empty
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < BHT_ENTRIES; i++) begin
                ctr_q[i] <= CTR_RESET;
            end
            ghr_q <= '0;
        end else if (upd_en_i) begin
            ctr_q[upd_idx] <= upd_ctr_next;
            // Newest outcome enters at bit 0
            ghr_q <= {ghr_q[`BP_GHR_WIDTH-2:0], upd_taken_i};
        end
    end

    // Update PC from execute must be fully known on a strobe
    a_upd_idx_known: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        upd_en_i |-> !$isunknown(upd_idx)
    ) else $error("BHT update index is unknown");

    // An unknown outcome would poison both the history and the counter
    a_upd_taken_known: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        upd_en_i |-> !$isunknown(upd_taken_i)
    ) else $error("BHT update outcome is unknown");

endmodule

// File: hw/bp_pkg.sv
// Branch predictor types

`include "bp_defines.svh"

package bp_pkg;

    // =======================================================================
    // Shared vector types
    // =======================================================================

    // Program counter or target address
    typedef logic [`BP_ADDR_WIDTH-1:0] addr_t;

    // Two-bit saturating direction counter
    // MSB set means predict taken
    typedef logic [1:0] ctr_t;

    // Global branch history
    // Bit 0 holds the most recent outcome
    typedef logic [`BP_GHR_WIDTH-1:0] ghr_t;

endpackage

// File: hw/branch_predictor.sv
// Fetch stage branch predictor
// BTB target lookup with gshare direction

`timescale 1ns/1ps

`include "bp_defines.svh"

module branch_predictor #(
    parameter int unsigned BTB_ENTRIES = `BP_BTB_ENTRIES,
    parameter int unsigned BHT_ENTRIES = `BP_BHT_ENTRIES
) (
    input  logic          clk_i,
    input  logic          rst_ni,

    // Prediction for the fetch PC in the same cycle
    input  bp_pkg::addr_t pc_i,
    output logic          predict_taken_o,
    output bp_pkg::addr_t predict_target_o,
    output logic          btb_hit_o,

    // Resolved branch from execute
    input  logic          update_i,
    input  logic          is_branch_i,
    input  bp_pkg::addr_t update_pc_i,
    input  logic          actual_taken_i,
    input  bp_pkg::addr_t actual_target_i
);

    logic          upd_en;
    logic          btb_hit;
    bp_pkg::addr_t btb_target;
    logic          bht_taken;

    // Non-branch strobes never reach the tables
    assign upd_en = update_i & is_branch_i;

    // =======================================================================
    // Tables
    // =======================================================================

    bp_btb #(
        .BTB_ENTRIES (BTB_ENTRIES)
    ) btb_i (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .lookup_pc_i (pc_i),
        .hit_o       (btb_hit),
        .target_o    (btb_target),
        .wr_en_i     (upd_en),
        .wr_pc_i     (update_pc_i),
        .wr_target_i (actual_target_i)
    );

    bp_gshare_bht #(
        .BHT_ENTRIES (BHT_ENTRIES)
    ) bht_i (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .lookup_pc_i (pc_i),
        .taken_o     (bht_taken),
        .upd_en_i    (upd_en),
        .upd_pc_i    (update_pc_i),
        .upd_taken_i (actual_taken_i)
    );

    // =======================================================================
    // Prediction
    // =======================================================================

    // Taken needs a known target so a BTB miss is always not-taken
    assign predict_taken_o = btb_hit & bht_taken;

    // Fall through to the next sequential instruction on a miss
    assign predict_target_o = btb_hit ? btb_target : pc_i + bp_pkg::addr_t'(4);

    assign btb_hit_o = btb_hit;

endmodule
